//--- obj_config.svh
/*
 * build parameters of the sprite line-table builder
 * include in every module that sizes memories, counters or the credit loop
 */
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

`define OBJ_TABLE_SPRITES 256                       // sprites in the frame RAM
`define OBJ_LINE_SLOTS    128                       // entries per video line
`define OBJ_CREDITS       2                         // expand record queue depth
`define OBJ_END_MARK      16'hFF00                  // attr word closing the table

// derived address widths
`define OBJ_RAM_AW  ($clog2(4 * `OBJ_TABLE_SPRITES))
`define OBJ_LINE_AW ($clog2(4 * `OBJ_LINE_SLOTS))  // one half of the line buffer

`endif

//--- obj_pkg.sv
/*
 * sprite record and attribute types shared by the scan and expand stages
 */
package obj_pkg;

    // attribute word as the expand stage sees it
    typedef struct packed {
        logic [3:0] tile_m;     // extra tiles downwards
        logic [3:0] tile_n;     // extra tiles to the right
        logic       rsv;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_f_t;

    // raw view for end marker and duplicate tests
    typedef union packed {
        logic [15:0] raw;
        obj_attr_f_t f;
    } obj_attr_u;

    // one table entry, in frame RAM word order
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        obj_attr_u   attr;
    } obj_sprite_t;

endpackage

//--- obj_frame_ram.sv
/*
 * sprite attribute table, four words per sprite
 * CPU side writes, the scan stage reads with one cycle latency
 */
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_frame_ram (
    input  logic                   clk,

    // cpu load port
    input  logic                   cpu_we,
    input  logic [`OBJ_RAM_AW-1:0] cpu_addr,
    input  logic [15:0]            cpu_din,

    // scan port
    input  logic [`OBJ_RAM_AW-1:0] rd_addr,
    output logic [15:0]            rd_data
);

    logic [15:0] mem [4 * `OBJ_TABLE_SPRITES];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- obj_scan.sv
/*
 * stage 1 of the line builder: walks the frame RAM, one sprite every 4 cycles,
 * drops repeated sprites, stops at the end marker and sends records under credits
 */
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_scan (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    output logic [`OBJ_RAM_AW-1:0] rd_addr,
    input  logic [15:0]            rd_data,
    output logic                   spr_valid,
    output obj_pkg::obj_sprite_t   spr,
    input  logic                   credit_ret,
    output logic                   scan_end
);
    import obj_pkg::*;

    localparam int CW = $clog2(`OBJ_CREDITS + 1);

    typedef enum logic [2:0] {S_IDLE, S_PRIME, S_FETCH, S_STALL, S_END} scan_st_t;

    scan_st_t      st;
    logic [CW-1:0] credits;
    logic [15:0]   x_r;
    logic [15:0]   y_r;
    logic [15:0]   code_r;
    obj_sprite_t   rec;
    obj_sprite_t   last_rec;
    logic          first;
    logic          last_spr;    // held record is the final table entry
    logic [1:0]    dsel;
    logic          end_hit;
    logic          dup;
    logic          wrapped;
    logic          send;

    // while fetching, rd_data always belongs to rd_addr - 1
    assign dsel    = rd_addr[1:0] - 2'd1;
    assign rec     = {x_r, y_r, code_r, rd_data};
    assign end_hit = rec.attr.raw == `OBJ_END_MARK;
    assign dup     = !first && (rec == last_rec);
    assign wrapped = rd_addr[`OBJ_RAM_AW-1:2] == '0;   // attr of the last sprite just read

    assign send = (st == S_FETCH && dsel == 2'd3 && !end_hit && !dup && credits != '0) ||
                  (st == S_STALL && credits != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CW'(`OBJ_CREDITS);
        end else begin
            credits <= credits + CW'(credit_ret) - CW'(send);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= S_IDLE;
            rd_addr   <= '0;
            spr_valid <= 1'b0;
            scan_end  <= 1'b0;
            first     <= 1'b0;
            last_spr  <= 1'b0;
        end else begin
            spr_valid <= send;
            scan_end  <= 1'b0;
            case (st)
                S_IDLE: begin
                    if (start) begin
                        rd_addr <= '0;
                        first   <= 1'b1;
                        st      <= S_PRIME;
                    end
                end
                S_PRIME: begin  // wait for the first RAM word
                    rd_addr <= rd_addr + 1'b1;
                    st      <= S_FETCH;
                end
                S_FETCH: begin
                    if (dsel == 2'd3) begin
                        first <= 1'b0;
                        if (end_hit) begin
                            st <= S_END;
                        end else if (!dup && credits == '0) begin
                            last_spr <= wrapped;
                            st       <= S_STALL;   // rd_addr held on next x word
                        end else if (wrapped) begin
                            st <= S_END;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                S_STALL: begin
                    if (credits != '0) begin
                        if (last_spr) begin
                            st <= S_END;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            st      <= S_FETCH;
                        end
                    end
                end
                default: begin
                    scan_end <= 1'b1;
                    st       <= S_IDLE;
                end
            endcase
        end
    end

    // record assembly
    always_ff @(posedge clk) begin
        if (st == S_FETCH) begin
            case (dsel)
                2'd0: x_r <= rd_data;
                2'd1: y_r <= rd_data;
                2'd2: code_r <= rd_data;
                default: begin
                    last_rec <= rec;
                    spr      <= rec;    // kept while stalled
                end
            endcase
        end
    end

    a_valid_credit: assert property (@(posedge clk) disable iff (rst)
        spr_valid |-> $past(credits) != '0);

    // expand must never return more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CW'(`OBJ_CREDITS));

endmodule

//--- obj_tile_expand.sv
/*
 * stage 2 of the line builder: queues sprite records, tests them against the
 * current line and emits three words per horizontal tile, one word per cycle
 */
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_tile_expand (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [8:0]           vrender,
    input  logic                 spr_valid,
    input  obj_pkg::obj_sprite_t spr,
    output logic                 credit_ret,
    input  logic                 scan_end,
    output logic                 ent_we,
    output logic [1:0]           ent_word,
    output logic [15:0]          ent_data,
    output logic                 ent_next,
    output logic                 line_end,
    input  logic                 line_full
);
    import obj_pkg::*;

    localparam int QW = (`OBJ_CREDITS > 1) ? $clog2(`OBJ_CREDITS) : 1;
    localparam int CW = $clog2(`OBJ_CREDITS + 1);

    typedef enum logic [1:0] {E_IDLE, E_CHECK, E_EMIT} exp_st_t;

    exp_st_t       st;
    obj_sprite_t   queue [`OBJ_CREDITS];
    obj_sprite_t   cur;
    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;
    logic          scan_done;
    logic [8:0]    d;
    logic          visible;
    logic [3:0]    m;
    logic [3:0]    row;
    logic [3:0]    vsub;
    logic [3:0]    n;
    logic [3:0]    npos;
    logic [1:0]    phase;
    logic          stop;

    function automatic logic [QW-1:0] ptr_inc(input logic [QW-1:0] p);
        return (p == QW'(`OBJ_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = (st == E_IDLE) && (count != '0);

    // vertical position inside the sprite
    assign d       = vrender - cur.y[8:0];
    assign visible = d[8:4] <= {1'b0, cur.attr.f.tile_m};
    assign m       = d[7:4];
    assign row     = cur.attr.f.vflip ? cur.attr.f.tile_m - m : m;
    assign vsub    = d[3:0] ^ {4{cur.attr.f.vflip}};
    assign npos    = cur.attr.f.hflip ? cur.attr.f.tile_n - n : n;

    assign stop     = (phase == 2'd0) && line_full;    // table filled, abandon sprite
    assign ent_we   = (st == E_EMIT) && !stop;
    assign ent_word = phase;
    assign ent_next = (st == E_EMIT) && (phase == 2'd2);

    always_comb begin
        case (phase)
            2'd0:    ent_data = {4'd0, vsub, cur.attr.raw[7:0]};
            2'd1:    ent_data = {cur.code[15:8], cur.code[7:4] + row, cur.code[3:0] + n};
            default: ent_data = cur.x + {8'd0, npos, 4'd0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (spr_valid) begin
            queue[wr_ptr] <= spr;
        end
        if (pop) begin
            cur <= queue[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= E_IDLE;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
            line_end   <= 1'b0;
            scan_done  <= 1'b0;
            n          <= '0;
            phase      <= '0;
        end else begin
            credit_ret <= pop;   // one credit back per popped record
            line_end   <= 1'b0;
            count      <= count + CW'(spr_valid) - CW'(pop);
            if (spr_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (scan_end) begin
                scan_done <= 1'b1;
            end
            case (st)
                E_IDLE: begin
                    if (pop) begin
                        rd_ptr <= ptr_inc(rd_ptr);
                        st     <= E_CHECK;
                    end else if (scan_done) begin
                        line_end  <= 1'b1;
                        scan_done <= 1'b0;
                    end
                end
                E_CHECK: begin
                    n     <= '0;
                    phase <= '0;
                    st    <= (visible && !line_full) ? E_EMIT : E_IDLE;
                end
                default: begin
                    if (stop) begin
                        st <= E_IDLE;
                    end else if (phase == 2'd2) begin
                        phase <= '0;
                        if (n == cur.attr.f.tile_n) begin
                            st <= E_IDLE;
                        end else begin
                            n <= n + 1'b1;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
            endcase
        end
    end

    a_queue_room: assert property (@(posedge clk) disable iff (rst)
        spr_valid |-> count < CW'(`OBJ_CREDITS));

endmodule

//--- obj_line_buf.sv
/*
 * stage 3 of the line builder: double-buffered line table
 * one half is written for the line being prepared, the renderer reads the other
 */
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_buf (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [8:0]              vrender,
    input  logic                    ent_we,
    input  logic [1:0]              ent_word,
    input  logic [15:0]             ent_data,
    input  logic                    ent_next,
    input  logic                    line_end,
    output logic                    line_full,
    output logic                    done,
    input  logic [`OBJ_LINE_AW-1:0] line_addr,
    output logic [15:0]             line_data
);

    localparam int SW = $clog2(`OBJ_LINE_SLOTS);
    localparam logic [SW:0] SLOTS = `OBJ_LINE_SLOTS;

    typedef enum logic [1:0] {B_IDLE, B_BUILD, B_FILL} buf_st_t;

    buf_st_t     st;
    logic [15:0] mem [2 * 4 * `OBJ_LINE_SLOTS];
    logic [SW:0] slot;
    logic        half;      // write half, latched at start
    logic [1:0]  fword;
    logic        wr_en;
    logic [1:0]  wr_word;
    logic [15:0] wr_data;

    assign line_full = slot == SLOTS;
    assign wr_en     = (st == B_FILL) || (st == B_BUILD && ent_we);
    assign wr_word   = (st == B_FILL) ? fword : ent_word;
    assign wr_data   = (st == B_FILL) ? '1 : ent_data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{half, slot[SW-1:0], wr_word}] <= wr_data;
        end
        line_data <= mem[{~vrender[0], line_addr}];    // renderer side
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= B_IDLE;
            slot  <= '0;
            half  <= 1'b0;
            fword <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (st)
                B_IDLE: begin
                    if (start) begin
                        half <= vrender[0];
                        slot <= '0;
                        st   <= B_BUILD;
                    end
                end
                B_BUILD: begin
                    if (ent_next && !line_full) begin
                        slot <= slot + 1'b1;
                    end
                    if (line_end) begin
                        fword <= '0;
                        if (line_full) begin
                            done <= 1'b1;   // nothing left to fill
                            st   <= B_IDLE;
                        end else begin
                            st <= B_FILL;
                        end
                    end
                end
                default: begin
                    if (fword == 2'd2) begin
                        fword <= '0;
                        slot  <= slot + 1'b1;
                        if (slot == SLOTS - 1'b1) begin
                            done <= 1'b1;
                            st   <= B_IDLE;
                        end
                    end else begin
                        fword <= fword + 1'b1;
                    end
                end
            endcase
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        ent_we |-> !line_full);

endmodule

//--- obj_line_top.sv
/*
 * sprite line-table builder, frame RAM plus the scan, expand and line buffer stages
 */
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cpu_we,
    input  logic [`OBJ_RAM_AW-1:0]  cpu_addr,
    input  logic [15:0]             cpu_din,
    input  logic                    start,
    input  logic [8:0]              vrender,
    output logic                    done,
    input  logic [`OBJ_LINE_AW-1:0] line_addr,
    output logic [15:0]             line_data
);
    import obj_pkg::*;

    logic [`OBJ_RAM_AW-1:0] rd_addr;
    logic [15:0]            rd_data;
    logic                   spr_valid;
    obj_sprite_t            spr;
    logic                   credit_ret;
    logic                   scan_end;
    logic                   ent_we;
    logic [1:0]             ent_word;
    logic [15:0]            ent_data;
    logic                   ent_next;
    logic                   line_end;
    logic                   line_full;

    obj_frame_ram u_ram (
        .clk      (clk),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .spr_valid  (spr_valid),
        .spr        (spr),
        .credit_ret (credit_ret),
        .scan_end   (scan_end)
    );

    obj_tile_expand u_expand (
        .clk        (clk),
        .rst        (rst),
        .vrender    (vrender),
        .spr_valid  (spr_valid),
        .spr        (spr),
        .credit_ret (credit_ret),
        .scan_end   (scan_end),
        .ent_we     (ent_we),
        .ent_word   (ent_word),
        .ent_data   (ent_data),
        .ent_next   (ent_next),
        .line_end   (line_end),
        .line_full  (line_full)
    );

    obj_line_buf u_buf (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .vrender   (vrender),
        .ent_we    (ent_we),
        .ent_word  (ent_word),
        .ent_data  (ent_data),
        .ent_next  (ent_next),
        .line_end  (line_end),
        .line_full (line_full),
        .done      (done),
        .line_addr (line_addr),
        .line_data (line_data)
    );

endmodule

//--- tb_obj_line.sv
/*
 * testbench for the sprite line-table builder
 * loads small sprite tables, builds lines and reads back the finished half,
 * concurrent assertions compare every word with a behavioral model
 */
`timescale 1ns/1ps
`include "obj_config.svh"

module tb_obj_line;

    localparam int RAM_AW      = `OBJ_RAM_AW;
    localparam int LINE_AW     = `OBJ_LINE_AW;
    localparam int SLOTS       = `OBJ_LINE_SLOTS;
    localparam int N_BUILDS    = 12;
    localparam int CASE_CYCLES = 4 * `OBJ_TABLE_SPRITES + 3 * 4 * `OBJ_LINE_SLOTS;

    logic               clk;
    logic               rst;
    logic               cpu_we;
    logic [RAM_AW-1:0]  cpu_addr;
    logic [15:0]        cpu_din;
    logic               start;
    logic [8:0]         vrender;
    logic               done;
    logic [LINE_AW-1:0] line_addr;
    logic [15:0]        line_data;

    logic [63:0]  tab [`OBJ_TABLE_SPRITES];    // {x, y, code, attr} per sprite
    int           n_spr;
    logic [15:0]  exp_line [4 * SLOTS];
    integer       seed = 32'ha06a_f423;
    logic         started;
    logic         chk_en;
    logic [15:0]  exp_val;
    logic         chk_q;
    logic [15:0]  exp_q;
    logic [LINE_AW-1:0] addr_q;

    obj_line_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .start     (start),
        .vrender   (vrender),
        .done      (done),
        .line_addr (line_addr),
        .line_data (line_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // line_data belongs to the address of the previous cycle
    always @(posedge clk) begin
        chk_q  <= chk_en;
        exp_q  <= exp_val;
        addr_q <= line_addr;
    end

    a_line_data: assert property (@(posedge clk) disable iff (rst)
        chk_q |-> line_data == exp_q)
    else begin
        $display("mismatch at %0t ns: line_data[%0d] is %h, expected %h", $time,
                 $sampled(addr_q), $sampled(line_data), $sampled(exp_q));
        $display("SOME TESTS FAILED");
        $fatal(1, "line table check failed");
    end

    a_done_idle: assert property (@(posedge clk) disable iff (rst)
        !started |-> !done)
    else begin
        $display("done pulsed at %0t ns before any start was given", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "early done");
    end

    initial begin
        repeat (N_BUILDS * CASE_CYCLES) @(posedge clk);
        $display("timeout at %0t ns: the line builder never finished a line", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [15:0] rand_word();
        return 16'($random(seed));
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic add_sprite(input logic [15:0] x, input logic [15:0] y,
                              input logic [15:0] code, input logic [15:0] attr);
        tab[n_spr] = {x, y, code, attr};
        n_spr++;
    endtask

    task automatic repeat_last();
        tab[n_spr] = tab[n_spr - 1];
        n_spr++;
    endtask

    task automatic load_table();
        for (int i = 0; i < n_spr; i++) begin
            for (int w = 0; w < 4; w++) begin
                cpu_we   = 1'b1;
                cpu_addr = RAM_AW'(4 * i + w);
                cpu_din  = tab[i][63 - 16 * w -: 16];
                next_cycle();
            end
        end
        cpu_we = 1'b0;
    endtask

    // expected line table, unwritten slots are all ones
    task automatic build_expected(input logic [8:0] line);
        int          slot;
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
        logic [8:0]  d;
        logic [3:0]  tm;
        logic [3:0]  tn;
        logic [3:0]  row;
        logic [3:0]  vsub;
        logic [3:0]  npos;
        slot = 0;
        for (int a = 0; a < 4 * SLOTS; a++) begin
            exp_line[a] = 16'hFFFF;
        end
        for (int i = 0; i < n_spr; i++) begin
            {x, y, code, attr} = tab[i];
            if (attr == `OBJ_END_MARK) break;
            if (i > 0 && tab[i] == tab[i - 1]) continue;   // duplicate of predecessor
            tm = attr[15:12];
            tn = attr[11:8];
            d  = line - y[8:0];
            if (d >= 16 * (tm + 1)) continue;
            row  = attr[6] ? tm - d[7:4] : d[7:4];
            vsub = attr[6] ? ~d[3:0] : d[3:0];
            for (int n = 0; n <= tn; n++) begin
                if (slot < SLOTS) begin
                    npos = attr[5] ? tn - 4'(n) : 4'(n);
                    exp_line[4 * slot]     = {4'd0, vsub, attr[7:0]};
                    exp_line[4 * slot + 1] = {code[15:8], code[7:4] + row, code[3:0] + 4'(n)};
                    exp_line[4 * slot + 2] = x + 16'(npos) * 16'd16;
                    slot++;
                end
            end
        end
    endtask

    // the opposite half of line + 1 is the half just built
    task automatic read_back(input logic [8:0] line);
        vrender = line + 9'd1;
        for (int a = 0; a < 4 * SLOTS; a++) begin
            line_addr = LINE_AW'(a);
            exp_val   = exp_line[a];
            chk_en    = (a % 4) != 3;   // fourth word of a slot is unused
            next_cycle();
        end
        chk_en = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic run_line(input logic [8:0] line);
        build_expected(line);
        vrender = line;
        start   = 1'b1;
        started = 1'b1;
        next_cycle();
        start = 1'b0;
        while (!done) begin
            next_cycle();
        end
        read_back(line);
    endtask

    initial begin
        rst       = 1'b1;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_din   = '0;
        start     = 1'b0;
        vrender   = '0;
        line_addr = '0;
        chk_en    = 1'b0;
        exp_val   = '0;
        started   = 1'b0;
        n_spr     = 0;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
        repeat (20) next_cycle();   // idle, done must stay low

        // single 1x1 sprite
        add_sprite(rand_word(), 16'd120, rand_word(), 16'h0003);
        add_sprite(rand_word(), rand_word(), rand_word(), `OBJ_END_MARK);
        load_table();
        run_line(9'd127);

        // duplicate and out-of-range sprites
        n_spr = 0;
        add_sprite(rand_word(), 16'd96, rand_word(), 16'h0011);
        repeat_last();
        add_sprite(rand_word(), 16'd101, rand_word(), 16'h0002);   // just below the line
        add_sprite(rand_word(), 16'd84, rand_word(), 16'h0004);    // one line too far
        add_sprite(rand_word(), 16'd90, rand_word(), 16'h0105);
        add_sprite(rand_word(), rand_word(), rand_word(), `OBJ_END_MARK);
        load_table();
        run_line(9'd100);

        // 3 wide by 2 tall, every flip combination, both tile rows
        for (int fl = 0; fl < 4; fl++) begin
            n_spr = 0;
            add_sprite(rand_word(), 16'd40, rand_word(),
                       {4'd1, 4'd2, 1'b0, fl[1], fl[0], 5'd9});
            add_sprite(rand_word(), rand_word(), rand_word(), `OBJ_END_MARK);
            load_table();
            run_line(9'd44);
            run_line(9'd67);
        end

        // sprites behind the end marker
        n_spr = 0;
        add_sprite(rand_word(), 16'd200, rand_word(), 16'h0001);
        add_sprite(rand_word(), rand_word(), rand_word(), `OBJ_END_MARK);
        add_sprite(rand_word(), 16'd205, rand_word(), 16'h0102);
        add_sprite(rand_word(), 16'd208, rand_word(), 16'h0006);
        add_sprite(rand_word(), rand_word(), rand_word(), `OBJ_END_MARK);
        load_table();
        run_line(9'd210);

        // 9 x 15 tiles, the line fills up inside the last sprite
        n_spr = 0;
        for (int k = 0; k < 9; k++) begin
            add_sprite(rand_word(), 16'd297, rand_word(), 16'h0E07);
        end
        add_sprite(rand_word(), rand_word(), rand_word(), `OBJ_END_MARK);
        load_table();
        run_line(9'd300);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
obj_pkg.sv
obj_frame_ram.sv
obj_scan.sv
obj_tile_expand.sv
obj_line_buf.sv
obj_line_top.sv
tb_obj_line.sv

//--- Bender.yml
package:
  name: obj_line

sources:
  - include_dirs:
      - .
    files:
      - obj_pkg.sv
      - obj_frame_ram.sv
      - obj_scan.sv
      - obj_tile_expand.sv
      - obj_line_buf.sv
      - obj_line_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_obj_line.sv
